// File: hdl/cpu_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_port import vic_pkg::*; (
  input  wire        clk_dot4x,
  input  wire        rst_n,
  input  wire        clk_phi,
  input  wire        commit_stb,
  input  wire reg_addr_t adi,
  input  wire  [7:0] dbi,
  input  wire        ce,        // low = selected
  input  wire        rw,        // low = write
  output logic [7:0] dbo,
  output logic       data_dir,  // high while we drive the data bus
  vic_reg_if.port    bus
);

  logic rd_q;     // qualified read, phi high
  logic wr_q;     // qualified write at commit
  logic wr_lock;  // at most one commit per phi high

  assign rd_q = !ce && rw && clk_phi;
  assign wr_q = !ce && !rw && commit_stb && !wr_lock;

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n)
      wr_lock <= 1'b0;
    else if (!clk_phi)
      wr_lock <= 1'b0;  // rearm during phi low
    else if (wr_q)
      wr_lock <= 1'b1;
  end

  // address goes straight to the read mux
  assign bus.addr   = adi;
  assign bus.wdata  = dbi;
  assign bus.wr_stb = wr_q;

  // replaces the transceiver, bus idles at zero
  assign data_dir = rd_q;
  assign dbo      = rd_q ? bus.rdata : 8'h00;

endmodule : cpu_bus_port

`default_nettype wire

// File: hdl/phase_gen.sv
`timescale 1ns/1ps
`include "vic_cfg.svh"
`default_nettype none

module phase_gen import vic_pkg::*; (
  input  wire  clk_dot4x,
  input  wire  rst_n,
  output logic clk_phi,     // cpu phi level
  output logic dot_tick,    // one clock in four
  output logic commit_stb   // last clock of phi high
);

  localparam int PHI_DIV = `VIC_PHI_DIV;
  localparam int HALF    = PHI_DIV / 2;
  localparam int CW      = $clog2(PHI_DIV);

  logic [CW-1:0] cnt;  // position within phi cycle
  phase_e        state;

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      state <= PH_LOW;
    end else begin
      cnt <= (cnt == CW'(PHI_DIV - 1)) ? '0 : cnt + 1'b1;
      if (cnt == CW'(HALF - 1))
        state <= PH_HIGH;               // second half of the cycle
      else if (cnt == CW'(PHI_DIV - 1))
        state <= PH_LOW;                // wrap back to low
    end
  end

  assign clk_phi = (state == PH_HIGH);  // straight from a flop, no glitches

  // 4x clock, so a dot ends every fourth count
  assign dot_tick = (cnt[1:0] == 2'b11);

  // phi falls at the edge after this, cpu data settled by now
  assign commit_stb = (state == PH_HIGH) && (cnt == CW'(PHI_DIV - 1));

endmodule : phase_gen

`default_nettype wire

// File: hdl/pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_out import vic_pkg::*; (
  input  wire    clk_dot4x,
  input  wire    rst_n,
  input  wire    in_win,
  input  wire    hs,
  input  wire    vs,
  input  wire color_t border_col,
  input  wire color_t bg_col,
  output logic   active,
  output logic   hsync,
  output logic   vsync,
  output chan_t  red,
  output chan_t  green,
  output chan_t  blue
);

  color_t pix;    // index for this dot
  logic   blank;  // any sync
  rgb_t   rgb;

  assign pix   = in_win ? bg_col : border_col;
  assign blank = hs || vs;
  assign rgb   = vic_palette[pix];

  // single output stage, one clock after xpos and raster
  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      red    <= '0;
      green  <= '0;
      blue   <= '0;
    end else begin
      active <= !blank;
      hsync  <= hs;
      vsync  <= vs;
      red    <= blank ? '0 : rgb.r;  // black during sync
      green  <= blank ? '0 : rgb.g;
      blue   <= blank ? '0 : rgb.b;
    end
  end

endmodule : pixel_out

`default_nettype wire

// File: hdl/raster_timer.sv
`timescale 1ns/1ps
`include "vic_cfg.svh"
`default_nettype none

module raster_timer import vic_pkg::*; (
  input  wire  clk_dot4x,
  input  wire  rst_n,
  input  wire  dot_tick,
  output xpos_t   xpos,
  output raster_t raster,
  output logic line_start,  // first clock of dot 0
  output logic hs,
  output logic vs,
  output logic in_win       // inside both windows
);

  localparam xpos_t   X_LAST = xpos_t'(`VIC_LINE_DOTS - 1);
  localparam raster_t Y_LAST = raster_t'(`VIC_FRAME_LINES - 1);
  localparam xpos_t   WIN_X0 = xpos_t'(`VIC_WIN_X0);
  localparam xpos_t   WIN_X1 = xpos_t'(`VIC_WIN_X1);
  localparam raster_t WIN_Y0 = raster_t'(`VIC_WIN_Y0);
  localparam raster_t WIN_Y1 = raster_t'(`VIC_WIN_Y1);
  localparam xpos_t   HS_X0  = xpos_t'(`VIC_HS_X0);
  localparam raster_t VS_Y0  = raster_t'(`VIC_VS_Y0);

  logic eol;     // tick that ends the last dot
  logic h_win;
  logic v_win;

  assign eol = dot_tick && (xpos == X_LAST);

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      xpos       <= '0;
      raster     <= '0;
      line_start <= 1'b0;
    end else begin
      line_start <= eol;  // raster already holds the new line
      if (dot_tick) begin
        if (xpos == X_LAST) begin
          xpos   <= '0;
          raster <= (raster == Y_LAST) ? '0 : raster + 1'b1;
        end else begin
          xpos <= xpos + 1'b1;
        end
      end
    end
  end

  // sync pulses run to the end of line / frame
  assign hs = (xpos >= HS_X0);
  assign vs = (raster >= VS_Y0);

  assign h_win  = (xpos >= WIN_X0) && (xpos <= WIN_X1);
  assign v_win  = (raster >= WIN_Y0) && (raster <= WIN_Y1);
  assign in_win = h_win && v_win;

endmodule : raster_timer

`default_nettype wire

// File: hdl/vic_cfg.svh
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

`default_nettype none

// clk_dot4x cycles per phi cycle, 8 dots of 4 cycles each
`define VIC_PHI_DIV 32

// frame geometry in dots and lines
`define VIC_LINE_DOTS   64
`define VIC_FRAME_LINES 40

// display window, inclusive bounds
`define VIC_WIN_X0 8
`define VIC_WIN_X1 55
`define VIC_WIN_Y0 4
`define VIC_WIN_Y1 35

`define VIC_HS_X0 60   // hsync runs to end of line
`define VIC_VS_Y0 38   // vsync runs to end of frame

`default_nettype wire

`endif

// File: hdl/vic_pkg.sv
`default_nettype none

package vic_pkg;

  typedef logic [5:0] xpos_t;      // dot within line
  typedef logic [8:0] raster_t;    // line number, 9 bits like the real chip
  typedef logic [3:0] color_t;     // palette index
  typedef logic [5:0] chan_t;      // one video channel
  typedef logic [5:0] reg_addr_t;  // cpu register address

  typedef enum logic {
    PH_LOW  = 1'b0,
    PH_HIGH = 1'b1
  } phase_e;

  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } rgb_t;

  // classic 16 color set, scaled to 6 bits per channel
  localparam rgb_t vic_palette [16] = '{
    '{6'h00, 6'h00, 6'h00}, '{6'h3f, 6'h3f, 6'h3f},  // black, white
    '{6'h1a, 6'h0d, 6'h0a}, '{6'h1c, 6'h29, 6'h2c},  // red, cyan
    '{6'h1b, 6'h0f, 6'h21}, '{6'h16, 6'h23, 6'h10},  // purple, green
    '{6'h0d, 6'h0a, 6'h1e}, '{6'h2e, 6'h31, 6'h1b},  // blue, yellow
    '{6'h1b, 6'h13, 6'h09}, '{6'h10, 6'h0e, 6'h00},  // orange, brown
    '{6'h26, 6'h19, 6'h16}, '{6'h11, 6'h11, 6'h11},  // light red, dark grey
    '{6'h1b, 6'h1b, 6'h1b}, '{6'h26, 6'h34, 6'h21},  // grey, light green
    '{6'h1b, 6'h17, 6'h2d}, '{6'h25, 6'h25, 6'h25}   // light blue, light grey
  };

endpackage : vic_pkg

`default_nettype wire

// File: hdl/vic_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// register access path, bus port to register block
interface vic_reg_if import vic_pkg::*;;

  reg_addr_t   addr;    // live cpu address
  logic [7:0]  wdata;   // write data, valid with wr_stb
  logic        wr_stb;  // one clock per committed write
  logic [7:0]  rdata;   // registered read mux, addr of last clock

  // bus side
  modport port (
    output addr,
    output wdata,
    output wr_stb,
    input  rdata
  );

  // register file side
  modport regs (
    input  addr,
    input  wdata,
    input  wr_stb,
    output rdata
  );

endinterface : vic_reg_if

`default_nettype wire

// File: hdl/vic_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vic_regs import vic_pkg::*; (
  input  wire     clk_dot4x,
  input  wire     rst_n,
  vic_reg_if.regs bus,
  input  wire raster_t raster,
  input  wire     line_start,
  output color_t  border_col,
  output color_t  bg_col,
  output logic    irq_n
);

  localparam reg_addr_t A_CTRL1  = 6'h11;  // raster bit 8 in bit 7
  localparam reg_addr_t A_RASTER = 6'h12;  // raster low byte
  localparam reg_addr_t A_IRQST  = 6'h19;
  localparam reg_addr_t A_IRQEN  = 6'h1a;
  localparam reg_addr_t A_BORDER = 6'h20;
  localparam reg_addr_t A_BG     = 6'h21;

  raster_t rc;        // raster compare line
  logic    irq_st;    // raster status bit
  logic    irq_en;    // raster enable bit
  logic    irq_pend;
  logic    rc_hit;
  logic    st_clr;

  // line_start comes with raster on the new line
  assign rc_hit = line_start && (raster == rc);

  // write one to clear
  assign st_clr = bus.wr_stb && (bus.addr == A_IRQST) && bus.wdata[0];

  assign irq_pend = irq_st && irq_en;
  assign irq_n    = !irq_pend;  // open drain style, low active

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      rc         <= '0;
      irq_en     <= 1'b0;
      border_col <= '0;
      bg_col     <= '0;
    end else if (bus.wr_stb) begin
      case (bus.addr)
        A_CTRL1:  rc[8]      <= bus.wdata[7];
        A_RASTER: rc[7:0]    <= bus.wdata;
        A_IRQEN:  irq_en     <= bus.wdata[0];
        A_BORDER: border_col <= color_t'(bus.wdata[3:0]);
        A_BG:     bg_col     <= color_t'(bus.wdata[3:0]);
        default:  ;  // status handled below, rest ignored
      endcase
    end
  end

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n)
      irq_st <= 1'b0;
    else if (rc_hit)
      irq_st <= 1'b1;  // a new hit beats a clear
    else if (st_clr)
      irq_st <= 1'b0;
  end

  // read mux, one clock behind addr
  always_ff @(posedge clk_dot4x) begin
    case (bus.addr)
      A_CTRL1:  bus.rdata <= {raster[8], 7'h7f};
      A_RASTER: bus.rdata <= raster[7:0];           // live line, not rc
      A_IRQST:  bus.rdata <= {irq_pend, 3'b111, 3'b000, irq_st};
      A_IRQEN:  bus.rdata <= {7'h7f, irq_en};
      A_BORDER: bus.rdata <= {4'hf, border_col};
      A_BG:     bus.rdata <= {4'hf, bg_col};
      default:  bus.rdata <= 8'hff;                 // unmapped
    endcase
  end

endmodule : vic_regs

`default_nettype wire

// File: hdl/vic_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_top import vic_pkg::*; (
  input  wire        clk_dot4x,  // the only clock
  input  wire        rst_n,
  input  wire reg_addr_t adi,    // low 6 address bits
  input  wire  [7:0] dbi,
  output logic [7:0] dbo,
  input  wire        ce,
  input  wire        rw,
  output logic       irq,        // active low
  output logic       clk_phi,
  output logic       data_dir,
  output logic       active,
  output logic       hsync,
  output logic       vsync,
  output chan_t      red,
  output chan_t      green,
  output chan_t      blue
);

  logic    dot_tick;
  logic    commit_stb;
  xpos_t   xpos;
  raster_t raster;
  logic    line_start;
  logic    hs;
  logic    vs;
  logic    in_win;
  color_t  border_col;
  color_t  bg_col;

  vic_reg_if bus_if ();  // bus port to regs

  phase_gen u_phase (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .clk_phi(clk_phi),
    .dot_tick(dot_tick), .commit_stb(commit_stb));

  raster_timer u_raster (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .dot_tick(dot_tick), .xpos(xpos),
    .raster(raster), .line_start(line_start), .hs(hs), .vs(vs), .in_win(in_win));

  vic_regs u_regs (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .bus(bus_if.regs), .raster(raster),
    .line_start(line_start), .border_col(border_col), .bg_col(bg_col), .irq_n(irq));

  cpu_bus_port u_port (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .clk_phi(clk_phi), .commit_stb(commit_stb),
    .adi(adi), .dbi(dbi), .ce(ce), .rw(rw), .dbo(dbo), .data_dir(data_dir),
    .bus(bus_if.port));

  pixel_out u_pix (
    .clk_dot4x(clk_dot4x), .rst_n(rst_n), .in_win(in_win), .hs(hs), .vs(vs),
    .border_col(border_col), .bg_col(bg_col), .active(active), .hsync(hsync),
    .vsync(vsync), .red(red), .green(green), .blue(blue));

endmodule : vic_top

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_vic -f tb.f -o Vtb_vic &&
./obj_dir/Vtb_vic ||
exit 1

// File: tb.f
+incdir+hdl
hdl/vic_pkg.sv
hdl/vic_reg_if.sv
hdl/phase_gen.sv
hdl/raster_timer.sv
hdl/vic_regs.sv
hdl/cpu_bus_port.sv
hdl/pixel_out.sv
hdl/vic_top.sv
tb/vic_checker.sv
tb/tb_vic.sv

// File: tb/tb_vic.sv
`timescale 1ns/1ps
`include "vic_cfg.svh"
`default_nettype none

module tb_vic import vic_pkg::*;;

  logic      clk_dot4x;
  logic      rst_n;
  reg_addr_t adi;
  logic [7:0] dbi;
  logic [7:0] dbo;
  logic      ce, rw, irq, clk_phi, data_dir, active, hsync, vsync;
  chan_t     red, green, blue;

  int        cycles;     // timeout counter
  int        tcnt;       // own position in frame, output side
  bit        track_ok;   // tcnt locked to vsync
  bit        pix_on;     // colors settled, check rgb
  logic      vs_prev;
  color_t    exp_border, exp_bg;

  vic_top uut (.*);

  initial begin
    clk_dot4x = 1'b0;
    forever #2 clk_dot4x = ~clk_dot4x;  // 4 ns
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input int exp, input int act);
    assert (exp == act) else
      fail_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  always @(posedge clk_dot4x) begin
    cycles <= cycles + 1;
    if (cycles >= 43000)  // four frames plus margin
      fail_run("timeout, the run did not finish in 43000 cycles");
  end

  task automatic bus_write(input reg_addr_t a, input logic [7:0] d);
    @(negedge clk_phi);
    @(posedge clk_dot4x);
    adi <= a;
    dbi <= d;
    ce  <= 1'b0;
    rw  <= 1'b0;
    @(negedge clk_phi);  // commit happened at this edge
    @(posedge clk_dot4x);
    ce <= 1'b1;
    rw <= 1'b1;
  endtask

  task automatic bus_read(input reg_addr_t a, output logic [7:0] d);
    @(negedge clk_phi);
    @(posedge clk_dot4x);
    adi <= a;
    ce  <= 1'b0;
    rw  <= 1'b1;
    @(posedge clk_phi);
    @(negedge clk_dot4x);
    check_eq("read data_dir", 1, int'(data_dir));
    d = dbo;
    @(posedge clk_dot4x);
    ce <= 1'b1;
  endtask

  // pixel tracker, sampled mid cycle
  always @(negedge clk_dot4x) begin
    int dot, line, idx;
    bit win, act;
    if (rst_n) begin
      if (vsync && !vs_prev) begin
        if (track_ok) check_eq("frame position", `VIC_VS_Y0 * 256, (tcnt + 1) % 10240);
        tcnt = `VIC_VS_Y0 * 256;
        track_ok = 1'b1;
      end else if (track_ok) begin
        tcnt = (tcnt + 1) % 10240;
      end
      vs_prev = vsync;
      if (track_ok) begin
        dot  = (tcnt % 256) / 4;
        line = tcnt / 256;
        act  = !(dot >= `VIC_HS_X0 || line >= `VIC_VS_Y0);
        win  = dot >= `VIC_WIN_X0 && dot <= `VIC_WIN_X1 &&
               line >= `VIC_WIN_Y0 && line <= `VIC_WIN_Y1;
        check_eq("active", int'(act), int'(active));
        check_eq("hsync", int'(dot >= `VIC_HS_X0), int'(hsync));
        if (!active) begin
          check_eq("blank rgb", 0, int'({red, green, blue}));
        end else if (pix_on) begin
          idx = win ? int'(exp_bg) : int'(exp_border);
          check_eq("red", int'(vic_palette[idx].r), int'(red));
          check_eq("green", int'(vic_palette[idx].g), int'(green));
          check_eq("blue", int'(vic_palette[idx].b), int'(blue));
        end
      end
    end
  end

  initial begin
    logic [7:0] d, rd;
    int line_sel;
    rd = 8'($urandom(92218));  // seed once
    rst_n    = 1'b0;
    adi      = '0;
    dbi      = '0;
    ce       = 1'b1;
    rw       = 1'b1;
    cycles   = 0;
    tcnt     = 0;
    track_ok = 1'b0;
    pix_on   = 1'b0;
    vs_prev  = 1'b0;
    @(negedge clk_dot4x);
    check_eq("reset irq", 1, int'(irq));
    check_eq("reset outputs", 0, int'({data_dir, hsync, vsync, active, clk_phi}));
    repeat (8) @(posedge clk_dot4x);
    rst_n <= 1'b1;

    // register readback, unused bits read as ones
    d = 8'($urandom);
    bus_write(6'h20, d);
    bus_read(6'h20, rd);
    check_eq("border readback", int'({4'hf, d[3:0]}), int'(rd));
    d = 8'($urandom);
    bus_write(6'h21, d);
    bus_read(6'h21, rd);
    check_eq("bg readback", int'({4'hf, d[3:0]}), int'(rd));
    bus_write(6'h12, 8'($urandom));
    bus_read(6'h11, rd);
    check_eq("raster bit 8", 8'h7f, int'(rd));
    d = 8'($urandom);
    bus_write(6'h1a, d);
    bus_read(6'h1a, rd);
    check_eq("enable readback", int'({7'h7f, d[0]}), int'(rd));
    bus_read(6'h3c, rd);
    check_eq("unused address", 8'hff, int'(rd));
    @(negedge clk_dot4x);
    check_eq("idle bus", 0, int'({data_dir, dbo}));

    // colors, then the tracker checks rgb for the rest of the run
    exp_border = color_t'($urandom);
    exp_bg     = exp_border + color_t'(1 + $urandom % 15);  // never the border color
    bus_write(6'h20, {4'h0, exp_border});
    bus_write(6'h21, {4'h0, exp_bg});
    pix_on = 1'b1;
    @(posedge vsync);  // tracker locks on this edge

    // raster interrupt on a random line
    line_sel = int'($urandom % 40);
    bus_write(6'h1a, 8'h00);
    bus_write(6'h11, 8'h00);
    bus_write(6'h12, 8'(line_sel));
    do bus_read(6'h12, rd); while (int'(rd) != (line_sel + 1) % 40);
    bus_write(6'h19, 8'h01);  // drop any old hit
    bus_write(6'h1a, 8'h01);
    @(negedge irq);
    bus_read(6'h12, rd);
    check_eq("irq line", line_sel, int'(rd));
    bus_write(6'h19, 8'h01);
    @(negedge clk_dot4x);
    check_eq("irq after clear", 1, int'(irq));

    // enable off, status still sets
    bus_write(6'h1a, 8'h00);
    repeat (10300) begin
      @(negedge clk_dot4x);
      check_eq("irq masked", 1, int'(irq));
    end
    bus_read(6'h19, rd);
    check_eq("status masked", 8'h71, int'(rd));

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_vic

`default_nettype wire

// File: tb/vic_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vic_checker (
  input wire       clk_dot4x,
  input wire       rst_n,
  input wire       clk_phi,
  input wire       hsync,
  input wire       vsync,
  input wire       data_dir,
  input wire [7:0] dbo,
  input wire       irq
);

  logic [15:0] phi_len;  // cycles since phi changed
  logic [15:0] hs_len;   // cycles of hsync high
  logic [15:0] ln_len;   // cycles since hsync rose
  logic [15:0] vs_len;
  logic [15:0] fr_len;   // cycles since vsync rose
  logic        phi_d, hs_d, vs_d;
  logic        phi_seen, ln_seen, fr_seen;  // first edge after reset is partial

  always_ff @(posedge clk_dot4x or negedge rst_n) begin
    if (!rst_n) begin
      phi_len  <= '0;
      hs_len   <= '0;
      ln_len   <= '0;
      vs_len   <= '0;
      fr_len   <= '0;
      phi_d    <= 1'b0;
      hs_d     <= 1'b0;
      vs_d     <= 1'b0;
      phi_seen <= 1'b0;
      ln_seen  <= 1'b0;
      fr_seen  <= 1'b0;
    end else begin
      phi_d   <= clk_phi;
      hs_d    <= hsync;
      vs_d    <= vsync;
      phi_len <= (clk_phi != phi_d) ? 16'd1 : phi_len + 16'd1;
      hs_len  <= hsync ? hs_len + 16'd1 : 16'd0;
      vs_len  <= vsync ? vs_len + 16'd1 : 16'd0;
      ln_len  <= (hsync && !hs_d) ? 16'd1 : ln_len + 16'd1;
      fr_len  <= (vsync && !vs_d) ? 16'd1 : fr_len + 16'd1;
      if (clk_phi != phi_d) phi_seen <= 1'b1;
      if (hsync && !hs_d)   ln_seen  <= 1'b1;
      if (vsync && !vs_d)   fr_seen  <= 1'b1;
    end
  end

  // phi half period 16 clocks
  a_phi: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    (clk_phi != phi_d) && phi_seen |-> phi_len == 16'd16) else $error("phi half period");
  a_hs_w: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    (!hsync && hs_d) |-> hs_len == 16'd16) else $error("hsync width");
  a_line: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    (hsync && !hs_d) && ln_seen |-> ln_len == 16'd256) else $error("line period");
  a_vs_w: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    (!vsync && vs_d) |-> vs_len == 16'd512) else $error("vsync width");  // 2 lines
  a_frame: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    (vsync && !vs_d) && fr_seen |-> fr_len == 16'd10240) else $error("frame period");
  a_idle: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    !data_dir |-> dbo == 8'h00) else $error("dbo driven while idle");
  a_dir: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    data_dir |-> clk_phi) else $error("data_dir outside phi high");

  // irq falls with the end of hsync at a line start, or at an enable commit
  a_irq: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    $fell(irq) |-> ($fell(hsync) || $fell(clk_phi))) else $error("irq fell off a line start");
  // release only by a write, which commits as phi falls
  a_irq_rel: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    $rose(irq) |-> $fell(clk_phi)) else $error("irq rose outside a write commit");

endmodule : vic_checker

bind vic_top vic_checker chk (.*);

`default_nettype wire
